// ==== Makefile ====
# Verilator build and run for the SDRAM memory subsystem

VERILATOR ?= verilator
TOP       ?= tb_sdram_mem
RTL_TOP   ?= sdram_mem_top
FLIST     ?= sdram_mem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== sdram_mem.f ====
verilog/sdram_pkg.sv
verilog/mem_arbiter.sv
verilog/mem_controller.sv
verilog/sdram_ctrl.sv
verilog/sdram_mem_top.sv
sim/sdram_chip_model.sv
sim/sdram_mem_sva.sv
sim/tb_sdram_mem.sv

// ==== sim/sdram_chip_model.sv ====
/* behavioral SDRAM device */
`timescale 1ns/100ps

module sdram_chip_model #(
    parameter int CAS_LATENCY = 2
) (
    input  logic                   clk,
    input  sdram_pkg::sdram_pins_t pins,
    input  sdram_pkg::mem_data_t   dq_out,
    input  logic                   dq_oe,
    output sdram_pkg::mem_data_t   dq_rd
);
    import sdram_pkg::*;

    mem_data_t   mem [logic [20:0]];        // written words only
    logic [10:0] open_row [4];
    mem_data_t   pipe [CAS_LATENCY-1];      // read data latency stages
    sdram_cmd_t  cmd;
    mem_addr_t   col_addr;

    // unwritten words read back a pattern of the full address
    function automatic mem_data_t read_word(input mem_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a, a[10:0]} ^ 32'h3c5a_96e1;
    endfunction

    assign cmd      = sdram_cmd_t'({pins.ras_n, pins.cas_n, pins.we_n});
    assign col_addr = {pins.ba, open_row[pins.ba], pins.a[7:0]};
    assign dq_rd    = pipe[CAS_LATENCY-2];

    always @(posedge clk) begin
        mem_data_t word;
        for (int i = CAS_LATENCY - 2; i > 0; i--) begin
            pipe[i] <= pipe[i-1];
        end
        pipe[0] <= '0;
        if (pins.cke && !pins.cs_n) begin
            case (cmd)
                CMD_ACTIVE: open_row[pins.ba] <= pins.a;
                CMD_READ:   pipe[0] <= read_word(col_addr);
                CMD_WRITE: begin
                    word = read_word(col_addr);
                    for (int b = 0; b < 4; b++) begin
                        if (!pins.dqm[b] && dq_oe) begin  // dqm low writes the byte
                            word[8*b +: 8] = dq_out[8*b +: 8];
                        end
                    end
                    mem[col_addr] = word;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== sim/sdram_mem_sva.sv ====
/* subsystem protocol checks */
`timescale 1ns/100ps

module sdram_mem_sva #(
    parameter int REFRESH_INTERVAL = 390
) (
    input logic                   clk,
    input logic                   resetn,
    input logic [1:0]             req_valid,
    input logic [1:0]             credit,
    input logic                   mem_initialized,
    input sdram_pkg::sdram_pins_t pins
);
    import sdram_pkg::*;

    logic [3:0]  pend [2];   // requests queued and not yet issued
    logic [3:0]  bank_open;
    int unsigned ref_gap;
    sdram_cmd_t  cmd;

    assign cmd = sdram_cmd_t'({pins.ras_n, pins.cas_n, pins.we_n});

    always @(posedge clk) begin
        if (!resetn) begin
            pend[0]   <= '0;
            pend[1]   <= '0;
            bank_open <= '0;
            ref_gap   <= 0;
        end else begin
            for (int c = 0; c < 2; c++) begin
                pend[c] <= pend[c] + 4'(req_valid[c]) - 4'(credit[c]);
            end
            if (cmd == CMD_ACTIVE) begin
                bank_open[pins.ba] <= 1'b1;
            end else if (cmd == CMD_READ || cmd == CMD_WRITE) begin
                bank_open[pins.ba] <= 1'b0;  // auto-precharge closes it
            end
            ref_gap <= (!mem_initialized || cmd == CMD_REFRESH) ? 0 : ref_gap + 1;
        end
    end

    a_credit_a: assert property (@(posedge clk) disable iff (!resetn)
        credit[0] |-> pend[0] != '0) else $error("credit_a without a queued request");
    a_credit_b: assert property (@(posedge clk) disable iff (!resetn)
        credit[1] |-> pend[1] != '0) else $error("credit_b without a queued request");
    a_activate: assert property (@(posedge clk) disable iff (!resetn)
        (cmd == CMD_READ || cmd == CMD_WRITE) |-> bank_open[pins.ba])
        else $error("read or write to a bank with no open row");
    a_refresh: assert property (@(posedge clk) disable iff (!resetn)
        ref_gap <= REFRESH_INTERVAL + 8) else $error("refresh spacing too long");

endmodule

bind sdram_mem_top sdram_mem_sva #(
    .REFRESH_INTERVAL (REFRESH_INTERVAL)
) u_sva (
    .clk             (clk),
    .resetn          (resetn),
    .req_valid       ({req_b_valid, req_a_valid}),
    .credit          ({credit_b, credit_a}),
    .mem_initialized (mem_initialized),
    .pins            (pins)
);

// ==== sim/tb_sdram_mem.sv ====
/* SDRAM subsystem testbench */
`timescale 1ns/100ps

module tb_sdram_mem;
    import sdram_pkg::*;

    localparam int NC          = 2;
    localparam int REF_INT     = 390;
    localparam int INIT_CYCLES = 200;
    localparam int CL          = 2;
    localparam int NUM_OPS     = 24;
    localparam int LIMIT = 2 * (16 + INIT_CYCLES + 30 + 40 * NUM_OPS + 3 * REF_INT);

    logic        clk;
    logic        resetn;
    logic        req_a_valid;
    logic        req_b_valid;
    mem_req_t    req_a;
    mem_req_t    req_b;
    mem_data_t   dq_in;
    mem_data_t   dq_out;
    mem_data_t   model_dq;
    logic        dq_oe;
    logic        credit_a;
    logic        credit_b;
    mem_rsp_t    rsp_a;
    mem_rsp_t    rsp_b;
    logic        mem_initialized;
    logic        fault;
    sdram_pins_t pins;

    int          credits [2];
    mem_data_t   exp_q [2][$];        // expected read data per client
    mem_data_t   ref_mem [logic [20:0]];
    logic [31:0] lcg_state = 32'ha8e2;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    sdram_mem_top #(
        .NUM_CREDITS (NC), .REFRESH_INTERVAL (REF_INT),
        .INIT_CYCLES (INIT_CYCLES), .CAS_LATENCY (CL)
    ) sdram_mem_top_i (
        .clk (clk), .resetn (resetn),
        .req_a_valid (req_a_valid), .req_a (req_a),
        .req_b_valid (req_b_valid), .req_b (req_b),
        .dq_in (dq_in), .credit_a (credit_a), .credit_b (credit_b),
        .rsp_a (rsp_a), .rsp_b (rsp_b),
        .mem_initialized (mem_initialized), .fault (fault),
        .pins (pins), .dq_out (dq_out), .dq_oe (dq_oe)
    );

    sdram_chip_model #(.CAS_LATENCY (CL)) chip (
        .clk (clk), .pins (pins), .dq_out (dq_out), .dq_oe (dq_oe), .dq_rd (model_dq)
    );

    assign dq_in = dq_oe ? dq_out : model_dq;

    always #10 clk = ~clk;

    function automatic mem_data_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic mem_data_t merge_bytes(input mem_data_t old, input mem_data_t nw,
                                              input byte_mask_t mask);
        mem_data_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) res[8*i +: 8] = nw[8*i +: 8];
        end
        return res;
    endfunction

    function automatic void check_response(input int c, input mem_data_t data);
        mem_data_t exp;
        checks++;
        if (exp_q[c].size() == 0) begin
            errors++;
            $display("time %0t: client %0d got a response it never asked for", $time, c);
        end else begin
            exp = exp_q[c].pop_front();
            if (data !== exp) begin
                errors++;
                $display("ERROR t=%0t rsp_%s.data got %h expected %h",
                         $time, (c == 0) ? "a" : "b", data, exp);
            end
        end
    endfunction

    // credits and responses sampled at the edge
    always @(posedge clk) begin
        cycles++;
        if (credit_a) credits[0]++;
        if (credit_b) credits[1]++;
        if (rsp_a.valid) check_response(0, rsp_a.data);
        if (rsp_b.valid) check_response(1, rsp_b.data);
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles with responses still missing", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_reqs();
        req_a_valid = 1'b0;
        req_b_valid = 1'b0;
    endtask

    task automatic issue(input int c, input logic wr, input mem_addr_t addr,
                         input mem_data_t data, input byte_mask_t mask);
        mem_req_t  r;
        mem_data_t old;
        r = '{write: wr, addr: addr, data: data, mask: mask};
        if (credits[c] == 0) begin
            errors++;
            $display("time %0t: client %0d sent a request with no credit", $time, c);
        end
        credits[c]--;
        if (wr) begin
            old = ref_mem.exists(addr) ? ref_mem[addr] : '0;
            ref_mem[addr] = merge_bytes(old, data, mask);
        end else begin
            exp_q[c].push_back(ref_mem[addr]);
        end
        if (c == 0) begin
            req_a_valid = 1'b1;
            req_a       = r;
        end else begin
            req_b_valid = 1'b1;
            req_b       = r;
        end
    endtask

    task automatic send(input int c, input logic wr, input mem_addr_t addr,
                        input mem_data_t data, input byte_mask_t mask);
        while (credits[c] == 0) next_cycle();
        issue(c, wr, addr, data, mask);
        next_cycle();
        clear_reqs();
    endtask

    task automatic drain();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0 ||
               credits[0] < NC || credits[1] < NC) begin
            next_cycle();
        end
    endtask

    task automatic init_timing();
        int n;
        n = 0;
        do begin
            next_cycle();
            n++;
            if (fault) begin
                errors++;
                $display("time %0t: fault raised during initialization", $time);
            end
        end while (!mem_initialized);
        checks++;
        if (n != INIT_CYCLES + 31) begin
            errors++;
            $display("ERROR t=%0t mem_initialized cycles got %0d expected %0d",
                     $time, n, INIT_CYCLES + 31);
        end
    endtask

    task automatic full_write_read();
        send(0, 1'b1, {2'd0, 11'h012, 8'h34}, next_rand(), 4'hf);
        drain();
        send(0, 1'b0, {2'd0, 11'h012, 8'h34}, '0, 4'h0);
        drain();
    endtask

    task automatic masked_write();
        send(0, 1'b1, {2'd1, 11'h155, 8'h0f}, next_rand(), 4'hf);
        send(0, 1'b1, {2'd1, 11'h155, 8'h0f}, next_rand(), 4'b0101);
        send(0, 1'b0, {2'd1, 11'h155, 8'h0f}, '0, 4'h0);
        drain();
    endtask

    task automatic interleaved_reads();
        send(0, 1'b1, {2'd2, 11'h0a0, 8'h01}, next_rand(), 4'hf);
        send(0, 1'b1, {2'd3, 11'h7ff, 8'hfe}, next_rand(), 4'hf);
        send(1, 1'b1, {2'd2, 11'h0a1, 8'h02}, next_rand(), 4'hf);
        send(1, 1'b1, {2'd1, 11'h3c3, 8'h80}, next_rand(), 4'hf);
        drain();
        issue(0, 1'b0, {2'd2, 11'h0a0, 8'h01}, '0, 4'h0);
        issue(1, 1'b0, {2'd2, 11'h0a1, 8'h02}, '0, 4'h0);
        next_cycle();
        issue(0, 1'b0, {2'd3, 11'h7ff, 8'hfe}, '0, 4'h0);
        issue(1, 1'b0, {2'd1, 11'h3c3, 8'h80}, '0, 4'h0);
        next_cycle();
        clear_reqs();
        drain();
    endtask

    task automatic credit_backpressure();
        issue(1, 1'b1, {2'd0, 11'h2aa, 8'h55}, next_rand(), 4'hf);
        next_cycle();
        issue(1, 1'b0, {2'd0, 11'h2aa, 8'h55}, '0, 4'h0);
        next_cycle();
        clear_reqs();
        checks++;
        if (credits[1] != 0) begin  // no credit can be back this early
            errors++;
            $display("ERROR t=%0t credits_b got %0d expected 0", $time, credits[1]);
        end
        drain();
        checks++;
        if (credits[1] != NC) begin
            errors++;
            $display("ERROR t=%0t credits_b got %0d expected %0d", $time, credits[1], NC);
        end
    endtask

    task automatic refresh_retention();
        int idx;
        idx = 0;
        repeat (3 * REF_INT) next_cycle();
        foreach (ref_mem[k]) begin
            send(idx % 2, 1'b0, mem_addr_t'(k), '0, 4'h0);
            idx++;
        end
        drain();
        checks++;
        if (fault) begin
            errors++;
            $display("ERROR t=%0t fault got 1 expected 0", $time);
        end
    endtask

    initial begin
        clk         = 1'b0;
        resetn      = 1'b0;
        req_a_valid = 1'b0;
        req_b_valid = 1'b0;
        req_a       = '0;
        req_b       = '0;
        credits[0]  = NC;
        credits[1]  = NC;
        repeat (16) @(posedge clk);
        #2;
        resetn = 1'b1;
        init_timing();
        full_write_read();
        masked_write();
        interleaved_reads();
        credit_backpressure();
        refresh_retention();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/mem_arbiter.sv ====
/* client queues and refresh arbiter */
`timescale 1ns/100ps

module mem_arbiter #(
    parameter int NUM_CREDITS      = 2,
    parameter int REFRESH_INTERVAL = 390
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 req_a_valid,
    input  sdram_pkg::mem_req_t  req_a,
    input  logic                 req_b_valid,
    input  sdram_pkg::mem_req_t  req_b,
    input  logic                 busy,
    input  logic                 mem_initialized,
    output logic                 credit_a,
    output logic                 credit_b,
    output logic                 op_valid,
    output sdram_pkg::mem_op_t   op
);
    import sdram_pkg::*;

    localparam int PTR_W = (NUM_CREDITS > 1) ? $clog2(NUM_CREDITS) : 1;
    localparam int CNT_W = $clog2(NUM_CREDITS + 1);
    localparam int REF_W = $clog2(REFRESH_INTERVAL);

    mem_req_t         q_mem [2][NUM_CREDITS];  // request storage per client
    logic [PTR_W-1:0] wr_ptr [2];
    logic [PTR_W-1:0] rd_ptr [2];
    logic [CNT_W-1:0] q_cnt [2];
    mem_req_t         push_req [2];
    logic [1:0]       push;
    logic [1:0]       pop;
    logic [1:0]       q_nonempty;
    logic [REF_W-1:0] ref_cnt;
    logic             ref_pending;
    client_id_t       last_id;                 // last client served
    client_id_t       pick_id;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(NUM_CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push        = {req_b_valid, req_a_valid};
    assign push_req[0] = req_a;
    assign push_req[1] = req_b;

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            q_nonempty[c] = (q_cnt[c] != '0);
        end
        // alternate only when both wait
        pick_id  = (q_nonempty == 2'b11) ? ~last_id : q_nonempty[1];
        op_valid = !busy && (ref_pending || q_nonempty != 2'b00);
        op       = '0;
        pop      = '0;
        if (ref_pending) begin
            op.refresh = 1'b1;                 // refresh beats both queues
        end else if (q_nonempty != 2'b00) begin
            op.req       = q_mem[pick_id][rd_ptr[pick_id]];
            op.client_id = pick_id;
            op.write     = op.req.write;
            op.read      = !op.req.write;
            pop[pick_id] = !busy;
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < 2; c++) begin
            if (push[c]) begin
                q_mem[c][wr_ptr[c]] <= push_req[c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int c = 0; c < 2; c++) begin
                wr_ptr[c] <= '0;
                rd_ptr[c] <= '0;
                q_cnt[c]  <= '0;
            end
            credit_a    <= 1'b0;
            credit_b    <= 1'b0;
            last_id     <= 1'b1;
            ref_cnt     <= '0;
            ref_pending <= 1'b0;
        end else begin
            for (int c = 0; c < 2; c++) begin
                if (push[c]) begin
                    wr_ptr[c] <= next_ptr(wr_ptr[c]);
                end
                if (pop[c]) begin
                    rd_ptr[c] <= next_ptr(rd_ptr[c]);
                end
                q_cnt[c] <= q_cnt[c] + CNT_W'(push[c]) - CNT_W'(pop[c]);
            end
            credit_a <= pop[0];  // one credit back per dequeue
            credit_b <= pop[1];
            if (pop != 2'b00) begin
                last_id <= pick_id;
            end
            if (op_valid && ref_pending) begin
                ref_pending <= 1'b0;
            end
            if (mem_initialized) begin
                if (ref_cnt == REF_W'(REFRESH_INTERVAL - 1)) begin
                    ref_cnt     <= '0;
                    ref_pending <= 1'b1;
                end else begin
                    ref_cnt <= ref_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/mem_controller.sv ====
/* memory operation controller */
`timescale 1ns/100ps

module mem_controller (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  op_valid,
    input  sdram_pkg::mem_op_t    op,
    input  logic                  drv_busy,
    input  logic                  drv_data_ready,
    input  sdram_pkg::mem_data_t  drv_dout,
    output logic                  busy,
    output logic                  mem_initialized,
    output logic                  fault,
    output sdram_pkg::mem_rsp_t   rsp_a,
    output sdram_pkg::mem_rsp_t   rsp_b,
    output logic                  drv_rd,
    output logic                  drv_wr,
    output logic                  drv_refresh,
    output sdram_pkg::mem_addr_t  drv_addr,
    output sdram_pkg::mem_data_t  drv_din,
    output sdram_pkg::byte_mask_t drv_mask
);
    import sdram_pkg::*;

    logic       accept;
    logic       drv_started;  // driver has picked up the strobe
    logic       op_read;
    client_id_t op_id;

    assign accept = mem_initialized && !busy && op_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy            <= 1'b1;
            mem_initialized <= 1'b0;
            fault           <= 1'b0;
            drv_rd          <= 1'b0;
            drv_wr          <= 1'b0;
            drv_refresh     <= 1'b0;
            drv_started     <= 1'b0;
            op_read         <= 1'b0;
            rsp_a.valid     <= 1'b0;
            rsp_b.valid     <= 1'b0;
        end else begin
            drv_rd      <= accept && op.read;
            drv_wr      <= accept && op.write;
            drv_refresh <= accept && op.refresh;
            rsp_a.valid <= 1'b0;
            rsp_b.valid <= 1'b0;
            if (!mem_initialized) begin
                if (!drv_busy) begin  // power-up sequence done
                    mem_initialized <= 1'b1;
                    busy            <= 1'b0;
                end
            end else if (accept) begin
                busy        <= 1'b1;
                drv_started <= 1'b0;
                op_read     <= op.read;
            end else if (busy && !drv_started) begin
                drv_started <= drv_busy;
            end else if (busy && !drv_busy) begin
                busy        <= 1'b0;
                drv_started <= 1'b0;
                op_read     <= 1'b0;
                if (op_read) begin
                    fault       <= fault | !drv_data_ready;  // sticky
                    rsp_a.valid <= drv_data_ready && (op_id == 1'b0);
                    rsp_b.valid <= drv_data_ready && (op_id == 1'b1);
                    if (op_id == 1'b0) begin
                        rsp_a.data <= drv_dout;
                    end else begin
                        rsp_b.data <= drv_dout;
                    end
                end
            end
        end
    end

    // held for the whole operation
    always_ff @(posedge clk) begin
        if (accept) begin
            drv_addr <= op.req.addr;
            drv_din  <= op.req.data;
            drv_mask <= op.req.mask;
            op_id    <= op.client_id;
        end
    end

endmodule

// ==== verilog/sdram_ctrl.sv ====
/* SDRAM command sequencer */
`timescale 1ns/100ps

module sdram_ctrl #(
    parameter int INIT_CYCLES = 200,
    parameter int CAS_LATENCY = 2
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  rd,
    input  logic                  wr,
    input  logic                  refresh,
    input  sdram_pkg::mem_addr_t  addr,
    input  sdram_pkg::mem_data_t  din,
    input  sdram_pkg::byte_mask_t mask,
    input  sdram_pkg::mem_data_t  dq_in,
    output sdram_pkg::mem_data_t  dout,
    output logic                  busy,
    output logic                  data_ready,
    output sdram_pkg::sdram_pins_t pins,
    output sdram_pkg::mem_data_t  dq_out,
    output logic                  dq_oe
);
    import sdram_pkg::*;

    localparam int CNT_W = $clog2(INIT_CYCLES + 32);

    // init sequence steps after the power-up wait
    localparam logic [CNT_W-1:0] SEQ_PRE  = CNT_W'(0);
    localparam logic [CNT_W-1:0] SEQ_REF1 = CNT_W'(2);
    localparam logic [CNT_W-1:0] SEQ_REF2 = CNT_W'(10);
    localparam logic [CNT_W-1:0] SEQ_MODE = CNT_W'(18);
    localparam logic [CNT_W-1:0] SEQ_END  = CNT_W'(29);
    localparam logic [CNT_W-1:0] RCD_END  = CNT_W'(1);
    localparam logic [CNT_W-1:0] WR_END   = CNT_W'(1);
    localparam logic [CNT_W-1:0] RFC_END  = CNT_W'(5);
    localparam logic [CNT_W-1:0] CAS_END  = CNT_W'(CAS_LATENCY - 1);

    // burst length 1, sequential, programmed CAS latency
    localparam logic [10:0] MODE_WORD = {4'b0000, 3'(CAS_LATENCY), 4'b0000};

    typedef enum logic [2:0] {
        ST_INIT_WAIT, ST_INIT_SEQ, ST_IDLE, ST_ACTIVE, ST_READ, ST_WRITE, ST_REFRESH
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;
    sdram_cmd_t       cmd;
    logic [1:0]       ba_r;
    logic [10:0]      a_r;
    logic [3:0]       dqm_r;
    logic             is_write;

    assign pins = {1'b1, 1'b0, cmd, ba_r, a_r, dqm_r};  // cke high, chip always selected

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= ST_INIT_WAIT;
            cnt        <= '0;
            busy       <= 1'b1;
            cmd        <= CMD_NOP;
            dq_oe      <= 1'b0;
            data_ready <= 1'b0;
            dqm_r      <= '0;
        end else begin
            cmd        <= CMD_NOP;
            dq_oe      <= 1'b0;
            data_ready <= 1'b0;
            dqm_r      <= '0;
            cnt        <= cnt + 1'b1;
            case (state)
                ST_INIT_WAIT: begin
                    if (cnt == CNT_W'(INIT_CYCLES - 1)) begin
                        state <= ST_INIT_SEQ;
                        cnt   <= '0;
                    end
                end
                ST_INIT_SEQ: begin
                    if (cnt == SEQ_PRE) begin
                        cmd     <= CMD_PRECHARGE;
                        a_r[10] <= 1'b1;  // all banks
                    end else if (cnt == SEQ_REF1 || cnt == SEQ_REF2) begin
                        cmd <= CMD_REFRESH;
                    end else if (cnt == SEQ_MODE) begin
                        cmd  <= CMD_MODE;
                        ba_r <= 2'b00;
                        a_r  <= MODE_WORD;
                    end else if (cnt == SEQ_END) begin
                        state <= ST_IDLE;
                        busy  <= 1'b0;
                    end
                end
                ST_IDLE: begin
                    cnt <= '0;
                    if (refresh) begin
                        cmd   <= CMD_REFRESH;
                        busy  <= 1'b1;
                        state <= ST_REFRESH;
                    end else if (rd || wr) begin
                        cmd      <= CMD_ACTIVE;
                        ba_r     <= addr.bank;
                        a_r      <= addr.row;
                        is_write <= wr;
                        busy     <= 1'b1;
                        state    <= ST_ACTIVE;
                    end
                end
                ST_ACTIVE: begin
                    if (cnt == RCD_END) begin  // tRCD met
                        cmd <= is_write ? CMD_WRITE : CMD_READ;
                        a_r <= {3'b100, addr.col};  // a10 set for auto-precharge
                        cnt <= '0;
                        if (is_write) begin
                            dq_out <= din;
                            dq_oe  <= 1'b1;
                            dqm_r  <= ~mask;
                            state  <= ST_WRITE;
                        end else begin
                            state <= ST_READ;
                        end
                    end
                end
                // data expected on dq_in CAS_LATENCY edges after the read edge
                ST_READ: begin
                    if (cnt == CAS_END) begin
                        dout       <= dq_in;
                        data_ready <= 1'b1;
                        busy       <= 1'b0;
                        state      <= ST_IDLE;
                    end
                end
                ST_WRITE: begin
                    if (cnt == WR_END) begin  // write recovery
                        busy  <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                ST_REFRESH: begin
                    if (cnt == RFC_END) begin
                        busy  <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/sdram_mem_top.sv ====
/* SDRAM memory subsystem */
`timescale 1ns/100ps

module sdram_mem_top #(
    parameter int NUM_CREDITS      = 2,
    parameter int REFRESH_INTERVAL = 390,
    parameter int INIT_CYCLES      = 200,
    parameter int CAS_LATENCY      = 2
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   req_a_valid,
    input  sdram_pkg::mem_req_t    req_a,
    input  logic                   req_b_valid,
    input  sdram_pkg::mem_req_t    req_b,
    input  sdram_pkg::mem_data_t   dq_in,
    output logic                   credit_a,
    output logic                   credit_b,
    output sdram_pkg::mem_rsp_t    rsp_a,
    output sdram_pkg::mem_rsp_t    rsp_b,
    output logic                   mem_initialized,
    output logic                   fault,
    output sdram_pkg::sdram_pins_t pins,
    output sdram_pkg::mem_data_t   dq_out,
    output logic                   dq_oe
);
    import sdram_pkg::*;

    logic       op_valid;
    mem_op_t    op;
    logic       busy;
    logic       drv_rd;
    logic       drv_wr;
    logic       drv_refresh;
    mem_addr_t  drv_addr;
    mem_data_t  drv_din;
    mem_data_t  drv_dout;
    byte_mask_t drv_mask;
    logic       drv_busy;
    logic       drv_data_ready;

    mem_arbiter #(
        .NUM_CREDITS      (NUM_CREDITS),
        .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) u_arbiter (
        .clk             (clk),
        .resetn          (resetn),
        .req_a_valid     (req_a_valid),
        .req_a           (req_a),
        .req_b_valid     (req_b_valid),
        .req_b           (req_b),
        .busy            (busy),
        .mem_initialized (mem_initialized),
        .credit_a        (credit_a),
        .credit_b        (credit_b),
        .op_valid        (op_valid),
        .op              (op)
    );

    mem_controller u_controller (
        .clk             (clk),
        .resetn          (resetn),
        .op_valid        (op_valid),
        .op              (op),
        .drv_busy        (drv_busy),
        .drv_data_ready  (drv_data_ready),
        .drv_dout        (drv_dout),
        .busy            (busy),
        .mem_initialized (mem_initialized),
        .fault           (fault),
        .rsp_a           (rsp_a),
        .rsp_b           (rsp_b),
        .drv_rd          (drv_rd),
        .drv_wr          (drv_wr),
        .drv_refresh     (drv_refresh),
        .drv_addr        (drv_addr),
        .drv_din         (drv_din),
        .drv_mask        (drv_mask)
    );

    sdram_ctrl #(
        .INIT_CYCLES (INIT_CYCLES),
        .CAS_LATENCY (CAS_LATENCY)
    ) u_sdram (
        .clk        (clk),
        .resetn     (resetn),
        .rd         (drv_rd),
        .wr         (drv_wr),
        .refresh    (drv_refresh),
        .addr       (drv_addr),
        .din        (drv_din),
        .mask       (drv_mask),
        .dq_in      (dq_in),
        .dout       (drv_dout),
        .busy       (drv_busy),
        .data_ready (drv_data_ready),
        .pins       (pins),
        .dq_out     (dq_out),
        .dq_oe      (dq_oe)
    );

endmodule

// ==== verilog/sdram_pkg.sv ====
/* SDRAM memory subsystem types */
package sdram_pkg;

    // word address, bank in the top bits
    typedef struct packed {
        logic [1:0]  bank;
        logic [10:0] row;
        logic [7:0]  col;
    } mem_addr_t;

    typedef logic [31:0] mem_data_t;
    typedef logic [3:0]  byte_mask_t;  // 1 writes that byte
    typedef logic        client_id_t;  // 0 is client a, 1 is client b

    typedef struct packed {
        logic       write;
        mem_addr_t  addr;
        mem_data_t  data;
        byte_mask_t mask;
    } mem_req_t;

    typedef struct packed {
        logic      valid;
        mem_data_t data;
    } mem_rsp_t;

    typedef struct packed {
        logic       read;
        logic       write;
        logic       refresh;
        client_id_t client_id;
        mem_req_t   req;
    } mem_op_t;

    typedef struct packed {
        logic        cke;
        logic        cs_n;
        logic        ras_n;
        logic        cas_n;
        logic        we_n;
        logic [1:0]  ba;
        logic [10:0] a;
        logic [3:0]  dqm;
    } sdram_pins_t;

    // values are {ras_n, cas_n, we_n}
    typedef enum logic [2:0] {
        CMD_NOP       = 3'b111,
        CMD_ACTIVE    = 3'b011,
        CMD_READ      = 3'b101,
        CMD_WRITE     = 3'b100,
        CMD_PRECHARGE = 3'b010,
        CMD_REFRESH   = 3'b001,
        CMD_MODE      = 3'b000
    } sdram_cmd_t;

endpackage
